// File: hw/credit_fifo.sv
// Flit queue that hands one credit back to its sender for every entry it frees
`timescale 1ns/1ps

module credit_fifo #(
   parameter int DEPTH = 4
) (
   input  logic                     fim_clk,
   input  logic                     csr_rst_n,
   input  logic                     push,
   input  pcie_edge_pkg::t_tlp_flit push_flit,
   output logic                     credit_ret,
   output logic                     not_empty,
   output pcie_edge_pkg::t_tlp_flit head,
   input  logic                     pop
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   pcie_edge_pkg::t_tlp_flit mem [DEPTH];
   logic [PTR_W-1:0]         wr_ptr;
   logic [PTR_W-1:0]         rd_ptr;
   logic [CNT_W-1:0]         count;
   logic                     do_pop;

   // Circular pointer advance for any depth
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign do_pop    = pop && not_empty;
   assign not_empty = (count != '0);
   assign head      = mem[rd_ptr];

   // Storage, sender holds a credit for every push so no full check
   always_ff @(posedge fim_clk) begin
      if (push) begin
         mem[wr_ptr] <= push_flit;
      end
   end

   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         credit_ret <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         count      <= count + CNT_W'(push) - CNT_W'(do_pop);
         // Credit goes back the cycle after the entry is freed
         credit_ret <= do_pop;
      end
   end

endmodule : credit_fifo

// File: hw/pcie_edge_pkg.sv
// PCIe host-edge package with flit, control-shadow and tag-mode types and credit constants
package pcie_edge_pkg;

   // -------------------------------------------------------------------------
   // TLP flit and type codes
   // -------------------------------------------------------------------------

   // One header-only TLP
   typedef struct packed {
      logic [7:0]  fmt_type;
      logic [9:0]  tag;
      logic [15:0] req_id;
      // Address for requests, status for completions
      logic [31:0] payload;
   } t_tlp_flit;

   localparam logic [7:0] FMT_MWR32 = 8'h40;
   localparam logic [7:0] FMT_MWR64 = 8'h60;
   localparam logic [7:0] FMT_CPL   = 8'h0A;

   // -------------------------------------------------------------------------
   // Control shadow and tag mode
   // -------------------------------------------------------------------------

   // 40-bit shadow word from the hard subsystem, top bit first
   typedef struct packed {
      logic [8:0]  rsvd_hi;
      logic        tag_enable_10bit;
      logic        extended_tag;
      logic [13:0] rsvd_lo;
      logic        vf_active;
      logic [10:0] vf_num;
      logic [2:0]  pf_num;
   } t_ctrl_shadow;

   // One-hot tag size
   typedef struct packed {
      logic tag_10bit;
      logic tag_8bit;
      logic tag_5bit;
   } t_tag_mode;

   // -------------------------------------------------------------------------
   // Queue depths and credits
   // -------------------------------------------------------------------------

   localparam int TX_DEPTH          = 4;
   localparam int RXREQ_DEPTH       = 2;
   localparam int HOST_TX_CREDITS   = 4;
   localparam int AFU_RXREQ_CREDITS = 4;
   localparam int MAX_CREDITS       = 4;
   localparam int CRED_W            = $clog2(MAX_CREDITS + 1);

   // Next credit count after one cycle of spending and returns
   function automatic logic [CRED_W-1:0] credit_next(input logic [CRED_W-1:0] cnt,
                                                     input logic spend,
                                                     input logic ret);
      return cnt + CRED_W'(ret) - CRED_W'(spend);
   endfunction

endpackage : pcie_edge_pkg

// File: hw/pcie_edge_top.sv
// PCIe host-edge top with TX forwarding, write commits, request merge and tag mode
`timescale 1ns/1ps

module pcie_edge_top (
   input  logic                        fim_clk,
   input  logic                        csr_rst_n,
   // AFU TX
   input  logic                        tx_in_valid,
   input  pcie_edge_pkg::t_tlp_flit    tx_in_flit,
   output logic                        tx_credit_ret,
   // Host TX
   output logic                        tx_out_valid,
   output pcie_edge_pkg::t_tlp_flit    tx_out_flit,
   input  logic                        host_tx_credit_ret,
   // Host requests (MMIO)
   input  logic                        host_rxreq_valid,
   input  pcie_edge_pkg::t_tlp_flit    host_rxreq_flit,
   output logic                        host_rxreq_credit_ret,
   // Merged requests to the AFU
   output logic                        rxreq_out_valid,
   output pcie_edge_pkg::t_tlp_flit    rxreq_out_flit,
   input  logic                        afu_rxreq_credit_ret,
   // Control shadow
   input  logic                        ctrl_shadow_valid,
   input  pcie_edge_pkg::t_ctrl_shadow ctrl_shadow,
   output pcie_edge_pkg::t_tag_mode    tag_mode
);

   logic                     tx_not_empty;
   pcie_edge_pkg::t_tlp_flit tx_head;
   logic                     tx_pop;

   // Request queue 0 is host MMIO, queue 1 is write commits
   logic                     rxq_push [2];
   pcie_edge_pkg::t_tlp_flit rxq_flit [2];
   logic                     rxq_credit [2];
   logic                     rxq_not_empty [2];
   pcie_edge_pkg::t_tlp_flit rxq_head [2];
   logic                     rxq_pop [2];

   // -------------------------------------------------------------------------
   // AFU to host path
   // -------------------------------------------------------------------------

   credit_fifo #(
      .DEPTH (pcie_edge_pkg::TX_DEPTH)
   ) tx_fifo_i (
      .fim_clk    (fim_clk),
      .csr_rst_n  (csr_rst_n),
      .push       (tx_in_valid),
      .push_flit  (tx_in_flit),
      .credit_ret (tx_credit_ret),
      .not_empty  (tx_not_empty),
      .head       (tx_head),
      .pop        (tx_pop)
   );

   write_commit_gen commit_gen_i (
      .fim_clk         (fim_clk),
      .csr_rst_n       (csr_rst_n),
      .head            (tx_head),
      .not_empty       (tx_not_empty),
      .pop             (tx_pop),
      .tx_valid        (tx_out_valid),
      .tx_flit         (tx_out_flit),
      .host_credit_ret (host_tx_credit_ret),
      .cmt_valid       (rxq_push[1]),
      .cmt_flit        (rxq_flit[1]),
      .cmt_credit_ret  (rxq_credit[1])
   );

   // -------------------------------------------------------------------------
   // Request path toward the AFU
   // -------------------------------------------------------------------------

   assign rxq_push[0]           = host_rxreq_valid;
   assign rxq_flit[0]           = host_rxreq_flit;
   assign host_rxreq_credit_ret = rxq_credit[0];

   for (genvar i = 0; i < 2; i++) begin : g_rxq
      credit_fifo #(
         .DEPTH (pcie_edge_pkg::RXREQ_DEPTH)
      ) rxq_fifo_i (
         .fim_clk    (fim_clk),
         .csr_rst_n  (csr_rst_n),
         .push       (rxq_push[i]),
         .push_flit  (rxq_flit[i]),
         .credit_ret (rxq_credit[i]),
         .not_empty  (rxq_not_empty[i]),
         .head       (rxq_head[i]),
         .pop        (rxq_pop[i])
      );
   end

   rxreq_arb rxreq_arb_i (
      .fim_clk        (fim_clk),
      .csr_rst_n      (csr_rst_n),
      .not_empty      (rxq_not_empty),
      .head           (rxq_head),
      .pop            (rxq_pop),
      .rx_valid       (rxreq_out_valid),
      .rx_flit        (rxreq_out_flit),
      .afu_credit_ret (afu_rxreq_credit_ret)
   );

   tag_mode_track tag_track_i (
      .fim_clk      (fim_clk),
      .csr_rst_n    (csr_rst_n),
      .shadow_valid (ctrl_shadow_valid),
      .shadow       (ctrl_shadow),
      .tag_mode     (tag_mode)
   );

endmodule : pcie_edge_top

// File: hw/rxreq_arb.sv
// Round-robin merge of two request queues toward the AFU under AFU credits
`timescale 1ns/1ps

module rxreq_arb (
   input  logic                     fim_clk,
   input  logic                     csr_rst_n,
   input  logic                     not_empty [2],
   input  pcie_edge_pkg::t_tlp_flit head [2],
   output logic                     pop [2],
   output logic                     rx_valid,
   output pcie_edge_pkg::t_tlp_flit rx_flit,
   input  logic                     afu_credit_ret
);

   logic [pcie_edge_pkg::CRED_W-1:0] afu_cred;
   logic                             prio;
   logic                             grant;
   logic                             sel;

   // Favoured queue first, the other one if it has nothing
   always_comb begin
      grant = 1'b0;
      sel   = prio;
      if (afu_cred != '0) begin
         if (not_empty[prio]) begin
            grant = 1'b1;
            sel   = prio;
         end else if (not_empty[!prio]) begin
            grant = 1'b1;
            sel   = !prio;
         end
      end
      pop[0] = grant && !sel;
      pop[1] = grant && sel;
   end

   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n) begin
         afu_cred <= pcie_edge_pkg::CRED_W'(pcie_edge_pkg::AFU_RXREQ_CREDITS);
         prio     <= 1'b0;
         rx_valid <= 1'b0;
      end else begin
         afu_cred <= pcie_edge_pkg::credit_next(afu_cred, grant, afu_credit_ret);
         rx_valid <= grant;
         if (grant) begin
            prio <= !prio;
         end
      end
   end

   always_ff @(posedge fim_clk) begin
      if (grant) begin
         rx_flit <= head[sel];
      end
   end

endmodule : rxreq_arb

// File: hw/tag_mode_track.sv
// Control-shadow register and one-hot PCIe tag mode tracker for PF0
`timescale 1ns/1ps

module tag_mode_track (
   input  logic                        fim_clk,
   input  logic                        csr_rst_n,
   input  logic                        shadow_valid,
   input  pcie_edge_pkg::t_ctrl_shadow shadow,
   output pcie_edge_pkg::t_tag_mode    tag_mode
);

   logic                        shadow_valid_q;
   pcie_edge_pkg::t_ctrl_shadow shadow_q;
   logic                        pf0_update;

   // -------------------------------------------------------------------------
   // Shadow capture
   // -------------------------------------------------------------------------

   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n) begin
         shadow_valid_q <= 1'b0;
      end else begin
         shadow_valid_q <= shadow_valid;
      end
   end

   always_ff @(posedge fim_clk) begin
      shadow_q <= shadow;
   end

   // Only the physical function 0 drives the mode
   assign pf0_update = shadow_valid_q && (shadow_q.pf_num == 3'd0) && !shadow_q.vf_active;

   // -------------------------------------------------------------------------
   // Tag mode, one-hot at all times
   // -------------------------------------------------------------------------

   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n) begin
         tag_mode <= 3'b001;
      end else if (pf0_update) begin
         if (shadow_q.extended_tag && shadow_q.tag_enable_10bit) begin
            tag_mode <= 3'b100;
         end else if (shadow_q.extended_tag) begin
            tag_mode <= 3'b010;
         end else begin
            // Legacy 5-bit tags
            tag_mode <= 3'b001;
         end
      end
   end

endmodule : tag_mode_track

// File: hw/write_commit_gen.sv
// Forwards AFU TX flits to the host and issues a commit completion for each write
`timescale 1ns/1ps

module write_commit_gen (
   input  logic                     fim_clk,
   input  logic                     csr_rst_n,
   input  pcie_edge_pkg::t_tlp_flit head,
   input  logic                     not_empty,
   output logic                     pop,
   output logic                     tx_valid,
   output pcie_edge_pkg::t_tlp_flit tx_flit,
   input  logic                     host_credit_ret,
   output logic                     cmt_valid,
   output pcie_edge_pkg::t_tlp_flit cmt_flit,
   input  logic                     cmt_credit_ret
);

   logic [pcie_edge_pkg::CRED_W-1:0] host_cred;
   logic [pcie_edge_pkg::CRED_W-1:0] cmt_cred;
   logic                             is_wr;
   logic                             host_ok;
   logic                             cmt_ok;

   // -------------------------------------------------------------------------
   // Pop decision
   // -------------------------------------------------------------------------

   assign is_wr   = (head.fmt_type == pcie_edge_pkg::FMT_MWR32) ||
                    (head.fmt_type == pcie_edge_pkg::FMT_MWR64);
   assign host_ok = (host_cred != '0);
   assign cmt_ok  = (cmt_cred != '0);

   // A write leaves only when its commit can leave in the same cycle
   assign pop = not_empty && host_ok && (!is_wr || cmt_ok);

   // -------------------------------------------------------------------------
   // Credits and registered outputs
   // -------------------------------------------------------------------------

   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n) begin
         host_cred <= pcie_edge_pkg::CRED_W'(pcie_edge_pkg::HOST_TX_CREDITS);
         cmt_cred  <= pcie_edge_pkg::CRED_W'(pcie_edge_pkg::RXREQ_DEPTH);
         tx_valid  <= 1'b0;
         cmt_valid <= 1'b0;
      end else begin
         host_cred <= pcie_edge_pkg::credit_next(host_cred, pop, host_credit_ret);
         cmt_cred  <= pcie_edge_pkg::credit_next(cmt_cred, pop && is_wr, cmt_credit_ret);
         tx_valid  <= pop;
         cmt_valid <= pop && is_wr;
      end
   end

   always_ff @(posedge fim_clk) begin
      if (pop) begin
         tx_flit           <= head;
         // Completion without data, zero status
         cmt_flit.fmt_type <= pcie_edge_pkg::FMT_CPL;
         cmt_flit.tag      <= head.tag;
         cmt_flit.req_id   <= head.req_id;
         cmt_flit.payload  <= '0;
      end
   end

endmodule : write_commit_gen

// File: pcie_edge_top.f
hw/pcie_edge_pkg.sv
hw/credit_fifo.sv
hw/write_commit_gen.sv
hw/rxreq_arb.sv
hw/tag_mode_track.sv
hw/pcie_edge_top.sv
tests/pcie_edge_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the PCIe host-edge testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --top-module pcie_edge_tb -f pcie_edge_top.f
./obj_dir/Vpcie_edge_tb > sim.log 2>&1 || true
cat sim.log
if grep -q '^\*\* PASS \*\*$' sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

// File: tests/pcie_edge_tb.sv
// Random-stimulus testbench for the PCIe host-edge block with a credit-aware reference model
`timescale 1ns/1ps

module pcie_edge_tb;

   localparam int N_TX       = 200;
   localparam int N_REQ      = 150;
   localparam int N_TAG      = 200;
   localparam int MAX_CYCLES = 20000;

   logic                        fim_clk;
   logic                        csr_rst_n;
   logic                        tx_in_valid;
   pcie_edge_pkg::t_tlp_flit    tx_in_flit;
   logic                        tx_credit_ret;
   logic                        tx_out_valid;
   pcie_edge_pkg::t_tlp_flit    tx_out_flit;
   logic                        host_tx_credit_ret;
   logic                        host_rxreq_valid;
   pcie_edge_pkg::t_tlp_flit    host_rxreq_flit;
   logic                        host_rxreq_credit_ret;
   logic                        rxreq_out_valid;
   pcie_edge_pkg::t_tlp_flit    rxreq_out_flit;
   logic                        afu_rxreq_credit_ret;
   logic                        ctrl_shadow_valid;
   pcie_edge_pkg::t_ctrl_shadow ctrl_shadow;
   pcie_edge_pkg::t_tag_mode    tag_mode;

   // Expected traffic, in order per source
   pcie_edge_pkg::t_tlp_flit tx_exp [$];
   pcie_edge_pkg::t_tlp_flit req_exp [$];
   pcie_edge_pkg::t_tlp_flit cmt_exp [$];

   logic [31:0] seed;
   // Credits held by the TB as sender, and credits owed by the TB as receiver
   int          tx_cred;
   int          req_cred;
   int          host_owed;
   int          afu_owed;
   int          tx_sent;
   int          req_sent;
   int          tx_ret_total;

   pcie_edge_top dut_i (.*);

   initial begin
      fim_clk = 1'b0;
      forever begin
         #50 fim_clk = ~fim_clk;
      end
   end

   // ------------------------------------------------------------------------
   // Random source and reference rules
   // ------------------------------------------------------------------------

   function automatic logic [31:0] rand_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic pcie_edge_pkg::t_tlp_flit rand_flit();
      logic [31:0]              r;
      pcie_edge_pkg::t_tlp_flit f;
      r = rand_next();
      case (r[31:30])
         2'd0:    f.fmt_type = pcie_edge_pkg::FMT_MWR32;
         2'd1:    f.fmt_type = pcie_edge_pkg::FMT_MWR64;
         2'd2:    f.fmt_type = 8'h00;
         default: f.fmt_type = 8'h20;
      endcase
      f.tag     = r[29:20];
      f.req_id  = r[19:4];
      f.payload = rand_next();
      return f;
   endfunction

   // PF0 without an active VF picks the tag size, anything else keeps it
   function automatic pcie_edge_pkg::t_tag_mode next_mode(input pcie_edge_pkg::t_tag_mode cur,
                                                         input logic vld,
                                                         input pcie_edge_pkg::t_ctrl_shadow s);
      pcie_edge_pkg::t_tag_mode m;
      m = cur;
      if (vld && (s.pf_num == 3'd0) && !s.vf_active) begin
         m.tag_10bit = s.extended_tag && s.tag_enable_10bit;
         m.tag_8bit  = s.extended_tag && !s.tag_enable_10bit;
         m.tag_5bit  = !s.extended_tag;
      end
      return m;
   endfunction

   task automatic stop_with_failure();
      $display("** FAIL **");
      $fatal(1);
   endtask

   task automatic report_failure(input string why);
      $display("Error: %s", why);
      stop_with_failure();
   endtask

   task automatic check_val(input string name, input logic [65:0] exp, input logic [65:0] act);
      if (exp !== act) begin
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         stop_with_failure();
      end
   endtask

   // ------------------------------------------------------------------------
   // Per-cycle model, sampled and driven on the falling edge
   // ------------------------------------------------------------------------

   task automatic observe_outputs();
      pcie_edge_pkg::t_tlp_flit f;
      if (tx_credit_ret) begin
         tx_cred++;
         tx_ret_total++;
      end
      if (host_rxreq_credit_ret) begin
         req_cred++;
      end
      if (tx_out_valid) begin
         if (host_owed >= pcie_edge_pkg::HOST_TX_CREDITS) begin
            report_failure("tx_out valid while the DUT holds no host credit");
         end else if (tx_exp.size() == 0) begin
            report_failure("tx_out valid with no flit outstanding");
         end else begin
            host_owed++;
            f = tx_exp.pop_front();
            check_val("tx_out flit", f, tx_out_flit);
            if ((f.fmt_type == pcie_edge_pkg::FMT_MWR32) ||
                (f.fmt_type == pcie_edge_pkg::FMT_MWR64)) begin
               // Commit is a zero-status completion for the same tag and requester
               f.fmt_type = pcie_edge_pkg::FMT_CPL;
               f.payload  = '0;
               cmt_exp.push_back(f);
            end
         end
      end
      if (rxreq_out_valid) begin
         if (afu_owed >= pcie_edge_pkg::AFU_RXREQ_CREDITS) begin
            report_failure("rxreq_out valid while the DUT holds no AFU credit");
         end else begin
            afu_owed++;
            if (rxreq_out_flit.fmt_type == pcie_edge_pkg::FMT_CPL) begin
               if (cmt_exp.size() == 0) begin
                  report_failure("commit on rxreq_out without a matching write");
               end else begin
                  check_val("commit flit", cmt_exp.pop_front(), rxreq_out_flit);
               end
            end else if (req_exp.size() == 0) begin
               report_failure("host request on rxreq_out that was never sent");
            end else begin
               check_val("host request flit", req_exp.pop_front(), rxreq_out_flit);
            end
         end
      end
   endtask

   task automatic drive_inputs(input bit drain);
      logic [31:0] r;
      r = rand_next();
      // Credits are withheld at random until all traffic is sent
      host_tx_credit_ret = 1'b0;
      if ((host_owed > 0) && (drain || r[31])) begin
         host_tx_credit_ret = 1'b1;
         host_owed--;
      end
      afu_rxreq_credit_ret = 1'b0;
      if ((afu_owed > 0) && (drain || (r[30] && r[27]))) begin
         afu_rxreq_credit_ret = 1'b1;
         afu_owed--;
      end
      tx_in_valid = 1'b0;
      if ((tx_sent < N_TX) && (tx_cred > 0) && r[29]) begin
         tx_in_flit  = rand_flit();
         tx_in_valid = 1'b1;
         tx_exp.push_back(tx_in_flit);
         tx_cred--;
         tx_sent++;
      end
      host_rxreq_valid = 1'b0;
      if ((req_sent < N_REQ) && (req_cred > 0) && r[28]) begin
         host_rxreq_flit  = rand_flit();
         host_rxreq_valid = 1'b1;
         req_exp.push_back(host_rxreq_flit);
         req_cred--;
         req_sent++;
      end
   endtask

   // ------------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------------

   initial begin
      pcie_edge_pkg::t_tag_mode    exp_mode;
      pcie_edge_pkg::t_ctrl_shadow old_sh;
      pcie_edge_pkg::t_ctrl_shadow mid_sh;
      logic                        old_vld;
      logic                        mid_vld;
      logic [31:0]                 r;
      logic [31:0]                 r2;
      int                          cyc;
      bit                          done;

      seed                 = 32'hbf88_a40e;
      csr_rst_n            = 1'b0;
      tx_in_valid          = 1'b0;
      tx_in_flit           = '0;
      host_tx_credit_ret   = 1'b0;
      host_rxreq_valid     = 1'b0;
      host_rxreq_flit      = '0;
      afu_rxreq_credit_ret = 1'b0;
      ctrl_shadow_valid    = 1'b0;
      ctrl_shadow          = '0;
      tx_cred              = pcie_edge_pkg::TX_DEPTH;
      req_cred             = pcie_edge_pkg::RXREQ_DEPTH;
      host_owed            = 0;
      afu_owed             = 0;
      tx_sent              = 0;
      req_sent             = 0;
      tx_ret_total         = 0;

      repeat (2) @(posedge fim_clk);
      @(negedge fim_clk);
      check_val("reset valids", 66'd0,
                {62'd0, tx_out_valid, tx_credit_ret, host_rxreq_credit_ret, rxreq_out_valid});
      check_val("reset tag_mode", {63'd0, 3'b001}, {63'd0, tag_mode});
      csr_rst_n = 1'b1;

      // Traffic under random back-pressure, then drain with full credit return
      done = 1'b0;
      for (cyc = 0; !done; cyc++) begin
         if (cyc >= MAX_CYCLES) begin
            report_failure("timeout while waiting for all traffic to drain");
         end else begin
            @(negedge fim_clk);
            observe_outputs();
            drive_inputs((tx_sent == N_TX) && (req_sent == N_REQ));
            done = (tx_sent == N_TX) && (req_sent == N_REQ) && (tx_exp.size() == 0) &&
                   (req_exp.size() == 0) && (cmt_exp.size() == 0) && (host_owed == 0) &&
                   (afu_owed == 0) && (tx_cred == pcie_edge_pkg::TX_DEPTH) &&
                   (req_cred == pcie_edge_pkg::RXREQ_DEPTH);
         end
      end
      // Idle cycles catch stray or duplicated flits
      repeat (8) begin
         @(negedge fim_clk);
         observe_outputs();
         drive_inputs(1'b1);
      end
      check_val("tx credit returns", 66'(N_TX), 66'(tx_ret_total));

      // Tag mode with a two-cycle pipeline in the model
      exp_mode = 3'b001;
      old_vld  = 1'b0;
      mid_vld  = 1'b0;
      old_sh   = '0;
      mid_sh   = '0;
      for (cyc = 0; cyc < N_TAG; cyc++) begin
         @(negedge fim_clk);
         exp_mode = next_mode(exp_mode, old_vld, old_sh);
         check_val("tag_mode", {63'd0, exp_mode}, {63'd0, tag_mode});
         old_vld = mid_vld;
         old_sh  = mid_sh;
         r  = rand_next();
         r2 = rand_next();
         ctrl_shadow_valid            = r[31] || r[30];
         ctrl_shadow.rsvd_hi          = r2[8:0];
         ctrl_shadow.tag_enable_10bit = r[22];
         ctrl_shadow.extended_tag     = r[23];
         ctrl_shadow.rsvd_lo          = r2[22:9];
         ctrl_shadow.vf_active        = r[25] && r[24];
         ctrl_shadow.vf_num           = r[21:11];
         ctrl_shadow.pf_num           = r[29] ? 3'd0 : r[28:26];
         mid_vld = ctrl_shadow_valid;
         mid_sh  = ctrl_shadow;
      end

      $display("** PASS **");
      $finish;
   end

endmodule : pcie_edge_tb
